// ==== include/bus_defines.svh ====
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// bus units that can raise a request, one reqv/ack bit each
`define BUS_NUM_REQ     11

// shifting queue slots, slot 0 is the tail
`define BUS_QUEUE_DEPTH 11

// destinations with an enable and a busy flag
// order is IE IO DE DO B0 B1 B2 B3 DMA
`define BUS_NUM_DEST    9

`endif

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    typedef struct packed {
        logic [1:0] domain;
        logic [1:0] subdomain;
    } unit_id_t;

    localparam unit_id_t UNIT_IE  = 4'b0000;
    localparam unit_id_t UNIT_IO  = 4'b0001;
    localparam unit_id_t UNIT_DE  = 4'b0100;
    localparam unit_id_t UNIT_DO  = 4'b0101;
    localparam unit_id_t UNIT_B0  = 4'b1000;
    localparam unit_id_t UNIT_B1  = 4'b1001;
    localparam unit_id_t UNIT_B2  = 4'b1010;
    localparam unit_id_t UNIT_B3  = 4'b1011;
    localparam unit_id_t UNIT_DMA = 4'b1100;

    typedef struct packed {
        unit_id_t send;
        unit_id_t dest;
    } bus_req_t;

    typedef struct packed {
        logic     valid;
        bus_req_t req;
    } queue_slot_t;

    // index into the free/busy vectors, illegal codes give 0 with the flag set
    function automatic logic [3:0] dest_index(input unit_id_t id, output logic illegal);
        illegal = 1'b0;
        case (id)
            UNIT_IE:  return 4'd0;
            UNIT_IO:  return 4'd1;
            UNIT_DE:  return 4'd2;
            UNIT_DO:  return 4'd3;
            UNIT_B0:  return 4'd4;
            UNIT_B1:  return 4'd5;
            UNIT_B2:  return 4'd6;
            UNIT_B3:  return 4'd7;
            UNIT_DMA: return 4'd8;
            default: begin
                illegal = 1'b1;
                return 4'd0;
            end
        endcase
    endfunction

endpackage

// ==== verilog/prio_arbiter.sv ====
module prio_arbiter #(
    parameter int N = 2
) (
    input  logic [N-1:0] request,
    output logic [N-1:0] grant_vec
);

    // later iterations overwrite earlier ones so the highest set bit wins
    always_comb begin
        grant_vec = '0;
        for (int i = 0; i < N; i++) begin
            if (request[i]) begin
                grant_vec = '0;
                grant_vec[i] = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/onehot_mux.sv ====
module onehot_mux #(
    parameter int N = 2
) (
    input  logic [N-1:0]                sel,
    input  bus_pkg::bus_req_t [N-1:0]   din,
    output bus_pkg::bus_req_t           dout
);

    import bus_pkg::*;

    // and-or mux, zero when nothing is selected
    always_comb begin
        dout = '0;
        for (int i = 0; i < N; i++) begin
            dout = dout | (din[i] & {$bits(bus_req_t){sel[i]}});
        end
    end

    // two selects at once would merge payloads silently
    a_sel_onehot: assert final ($isunknown(sel) || $onehot0(sel))
        else $error("onehot_mux: sel %b not one-hot", sel);

endmodule

// ==== verilog/bus_req_queue.sv ====
`include "bus_defines.svh"

module bus_req_queue (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  bus_pkg::bus_req_t [`BUS_NUM_REQ-1:0]  req,
    input  logic [`BUS_NUM_REQ-1:0]               reqv,
    input  logic                                  pull,
    input  logic [`BUS_NUM_DEST-1:0]              free,
    output logic [`BUS_NUM_REQ-1:0]               ack,
    output logic                                  grant,
    output bus_pkg::bus_req_t                     grant_req,
    output bus_pkg::unit_id_t                     dispatch_dest
);

    import bus_pkg::*;

    localparam int NREQ  = `BUS_NUM_REQ;
    localparam int DEPTH = `BUS_QUEUE_DEPTH;

    queue_slot_t              slot_q [DEPTH];
    queue_slot_t              slot_d [DEPTH];
    bus_req_t [DEPTH-1:0]     slot_req;
    logic [DEPTH-1:0]         ready;
    logic [DEPTH-1:0]         disp_sel;
    logic [DEPTH-1:0]         ld;
    logic [NREQ-1:0]          in_sel;
    bus_req_t                 in_req;
    logic [3:0]               grant_idx;
    logic                     grant_bad;

    // intake side
    prio_arbiter #(.N(NREQ)) u_in_arb (
        .request   (reqv),
        .grant_vec (in_sel)
    );

    onehot_mux #(.N(NREQ)) u_in_mux (
        .sel  (in_sel),
        .din  (req),
        .dout (in_req)
    );

    assign ack = in_sel & {NREQ{ld[0]}}; // no ack when the tail is stuck

    // readiness per slot, illegal destinations never become ready
    always_comb begin
        logic [3:0] idx;
        logic       bad;
        for (int k = 0; k < DEPTH; k++) begin
            idx         = dest_index(slot_q[k].req.dest, bad);
            ready[k]    = slot_q[k].valid & pull & ~bad & free[idx];
            slot_req[k] = slot_q[k].req;
        end
    end

    // dispatch side, oldest ready slot wins
    prio_arbiter #(.N(DEPTH)) u_disp_arb (
        .request   (ready),
        .grant_vec (disp_sel)
    );

    onehot_mux #(.N(DEPTH)) u_disp_mux (
        .sel  (disp_sel),
        .din  (slot_req),
        .dout (grant_req)
    );

    assign grant         = |ready;
    assign dispatch_dest = grant_req.dest;

    // a slot shifts when anything at or above it is empty or leaving
    always_comb begin
        ld[DEPTH-1] = ~slot_q[DEPTH-1].valid | disp_sel[DEPTH-1];
        for (int k = DEPTH - 2; k >= 0; k--) begin
            ld[k] = ld[k+1] | ~slot_q[k].valid | disp_sel[k];
        end
    end

    always_comb begin
        slot_d[0].valid = |reqv;
        slot_d[0].req   = in_req;
        for (int k = 1; k < DEPTH; k++) begin
            // an entry leaving this cycle must not move up as a copy
            slot_d[k].valid = slot_q[k-1].valid & ~disp_sel[k-1];
            slot_d[k].req   = slot_q[k-1].req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < DEPTH; k++) begin
                slot_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < DEPTH; k++) begin
                if (ld[k]) begin
                    slot_q[k] <= slot_d[k];
                end
            end
        end
    end

    always_comb begin
        grant_idx = dest_index(grant_req.dest, grant_bad);
    end

    // an acked request lands in the tail at the next edge
    a_ack_loads: assert property (@(posedge clk) disable iff (!rst_n)
        |ack |=> slot_q[0].valid && slot_q[0].req == $past(in_req))
        else $error("bus_req_queue: acked request missing from slot 0");

    a_grant_free: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> !grant_bad && free[grant_idx])
        else $error("bus_req_queue: grant to destination %h not free", grant_req.dest);

endmodule

// ==== verilog/dest_status.sv ====
`include "bus_defines.svh"

module dest_status (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_wr,
    input  logic [`BUS_NUM_DEST-1:0]  cfg_enable,
    input  logic [`BUS_NUM_DEST-1:0]  done,
    input  logic                      dispatch,
    input  bus_pkg::unit_id_t         dispatch_dest,
    output logic [`BUS_NUM_DEST-1:0]  free
);

    import bus_pkg::*;

    localparam int NDEST = `BUS_NUM_DEST;

    logic [NDEST-1:0] enable;
    logic [NDEST-1:0] busy;
    logic [NDEST-1:0] disp_vec;
    logic [3:0]       disp_idx;
    logic             disp_bad;

    always_comb begin
        disp_idx = dest_index(dispatch_dest, disp_bad);
        disp_vec = '0;
        if (dispatch && !disp_bad) begin
            disp_vec[disp_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= '1; // everything enabled out of reset
        end else if (cfg_wr) begin
            enable <= cfg_enable;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= disp_vec | (busy & ~done); // set beats done in the same cycle
        end
    end

    assign free = enable & ~busy;

    // the queue only sees registered free, so a busy target means a stale view
    a_no_busy_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch && !disp_bad |-> !busy[disp_idx])
        else $error("dest_status: dispatch to busy destination %0d", disp_idx);

endmodule

// ==== verilog/bus_arb_top.sv ====
`include "bus_defines.svh"

module bus_arb_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  bus_pkg::bus_req_t [`BUS_NUM_REQ-1:0]  req,
    input  logic [`BUS_NUM_REQ-1:0]               reqv,
    input  logic                                  pull,
    output logic [`BUS_NUM_REQ-1:0]               ack,
    output logic                                  grant,
    output bus_pkg::bus_req_t                     grant_req,
    input  logic [`BUS_NUM_DEST-1:0]              done,
    input  logic                                  cfg_wr,
    input  logic [`BUS_NUM_DEST-1:0]              cfg_enable
);

    import bus_pkg::*;

    logic [`BUS_NUM_DEST-1:0] free;
    unit_id_t                 dispatch_dest;

    bus_req_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .reqv          (reqv),
        .pull          (pull),
        .free          (free),
        .ack           (ack),
        .grant         (grant),
        .grant_req     (grant_req),
        .dispatch_dest (dispatch_dest)
    );

    // grant is the dispatch strobe
    dest_status u_status (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_enable    (cfg_enable),
        .done          (done),
        .dispatch      (grant),
        .dispatch_dest (dispatch_dest),
        .free          (free)
    );

endmodule

// ==== tb/tb_bus_arb_checks.sv ====
`include "bus_defines.svh"

module tb_bus_arb_checks (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  bus_pkg::bus_req_t [`BUS_NUM_REQ-1:0]  req,
    input  logic [`BUS_NUM_REQ-1:0]               reqv,
    input  logic                                  pull,
    input  logic [`BUS_NUM_REQ-1:0]               ack,
    input  logic                                  grant,
    input  bus_pkg::bus_req_t                     grant_req,
    input  logic [`BUS_NUM_DEST-1:0]              done,
    input  logic                                  cfg_wr,
    input  logic [`BUS_NUM_DEST-1:0]              cfg_enable,
    output int                                    errors,
    output int                                    queued
);
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;

    localparam int NREQ  = `BUS_NUM_REQ;
    localparam int DEPTH = `BUS_QUEUE_DEPTH;
    localparam int NDEST = `BUS_NUM_DEST;

    bus_req_t         model_q [DEPTH]; // index 0 is the oldest accepted request
    int               model_cnt = 0;
    logic [NDEST-1:0] en_m;
    logic [NDEST-1:0] busy_m;
    logic             exp_grant;
    bus_req_t         exp_req;
    int               exp_pos;
    logic [NREQ-1:0]  exp_ack;
    int               err_cnt = 0;

    assign errors = err_cnt;
    assign queued = model_cnt;

    // domain picks the group, subdomain the unit inside it, -1 for unused codes
    function automatic int dest_pos(input logic [3:0] code);
        case (code[3:2])
            2'd0, 2'd1: return code[1] ? -1 : int'(code[2]) * 2 + int'(code[0]);
            2'd2:       return 4 + int'(code[1:0]);
            default:    return (code[1:0] == 2'd0) ? 8 : -1;
        endcase
    endfunction

    always_comb begin
        int p;
        exp_grant = 1'b0;
        exp_req   = '0;
        exp_pos   = 0;
        for (int i = 0; i < DEPTH; i++) begin
            p = dest_pos(model_q[i].dest);
            if (!exp_grant && i < model_cnt && pull && p >= 0) begin
                if (en_m[p] && !busy_m[p]) begin
                    exp_grant = 1'b1;
                    exp_req   = model_q[i];
                    exp_pos   = i;
                end
            end
        end
        exp_ack = '0;
        if (model_cnt < DEPTH || exp_grant) begin // a full queue takes only while it drains
            for (int i = NREQ - 1; i >= 0; i--) begin
                if (reqv[i] && exp_ack == '0) begin
                    exp_ack[i] = 1'b1;
                end
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        logic             g;
        int               gp;
        logic [NREQ-1:0]  a;
        logic [NDEST-1:0] set_v;
        if (!rst_n) begin
            model_cnt = 0;
            en_m      = '1;
            busy_m    = '0;
            for (int i = 0; i < DEPTH; i++) begin
                model_q[i] = '0;
            end
        end else begin
            g     = exp_grant;
            gp    = exp_pos;
            a     = exp_ack;
            set_v = '0;
            if (g) begin
                set_v[dest_pos(model_q[gp].dest)] = 1'b1;
                for (int i = gp; i < DEPTH - 1; i++) begin
                    model_q[i] = model_q[i+1];
                end
                model_cnt--;
            end
            for (int i = 0; i < NREQ; i++) begin
                if (a[i] && model_cnt < DEPTH) begin
                    model_q[model_cnt] = req[i];
                    model_cnt++;
                end
            end
            busy_m = set_v | (busy_m & ~done);
            if (cfg_wr) begin
                en_m = cfg_enable;
            end
        end
    end

    a_ack_exp: assert property (@(posedge clk) disable iff (!rst_n) ack == exp_ack)
        else begin
            err_cnt++;
            $display("[ERROR] %0t ack exp %h got %h", $time, $sampled(exp_ack), $sampled(ack));
        end

    a_grant_exp: assert property (@(posedge clk) disable iff (!rst_n) grant == exp_grant)
        else begin
            err_cnt++;
            $display("[ERROR] %0t grant exp %b got %b", $time, $sampled(exp_grant),
                     $sampled(grant));
        end

    a_grant_req_exp: assert property (@(posedge clk) disable iff (!rst_n)
        exp_grant |-> grant_req == exp_req)
        else begin
            err_cnt++;
            $display("[ERROR] %0t grant_req exp %h got %h", $time, $sampled(exp_req),
                     $sampled(grant_req));
        end

    a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> dest_pos(grant_req.dest) >= 0)
        else begin
            err_cnt++;
            $display("%0t grant went to an illegal destination code", $time);
        end

    a_idle_no_grant: assert property (@(posedge clk) disable iff (!rst_n) !pull |-> !grant)
        else begin
            err_cnt++;
            $display("%0t grant was given while pull was low", $time);
        end

endmodule

// ==== tb/tb_bus_arb_top.sv ====
`include "bus_defines.svh"

module tb_bus_arb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;

    localparam int NREQ  = `BUS_NUM_REQ;
    localparam int NDEST = `BUS_NUM_DEST;

    logic                clk = 1'b0;
    logic                rst_n;
    bus_req_t [NREQ-1:0] req;
    logic [NREQ-1:0]     reqv;
    logic [NREQ-1:0]     ack;
    logic [NREQ-1:0]     ack_seen;
    logic                pull;
    logic                grant;
    logic                grant_seen;
    logic                stall_seen;
    bus_req_t            grant_req;
    bus_req_t            grant_req_seen;
    logic [NDEST-1:0]    done;
    logic                cfg_wr;
    logic [NDEST-1:0]    cfg_enable;
    int                  chk_errors;
    int                  queued;
    int                  other_errors = 0;
    int                  acked = 0;
    int                  granted = 0;
    int                  illegal_sent = 0;
    int                  done_timer [NDEST];
    bit                  new_reqs = 1'b0;
    bit                  pull_rand = 1'b0;
    bit                  cfg_rand = 1'b0;
    unit_id_t            units [NDEST] = '{UNIT_IE, UNIT_IO, UNIT_DE, UNIT_DO, UNIT_B0,
                                           UNIT_B1, UNIT_B2, UNIT_B3, UNIT_DMA};

    always #2 clk = ~clk;

    bus_arb_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .reqv       (reqv),
        .pull       (pull),
        .ack        (ack),
        .grant      (grant),
        .grant_req  (grant_req),
        .done       (done),
        .cfg_wr     (cfg_wr),
        .cfg_enable (cfg_enable)
    );

    tb_bus_arb_checks chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .reqv       (reqv),
        .pull       (pull),
        .ack        (ack),
        .grant      (grant),
        .grant_req  (grant_req),
        .done       (done),
        .cfg_wr     (cfg_wr),
        .cfg_enable (cfg_enable),
        .errors     (chk_errors),
        .queued     (queued)
    );

    function automatic int unit_pos(input unit_id_t id);
        for (int i = 0; i < NDEST; i++) begin
            if (units[i] == id) begin
                return i;
            end
        end
        return -1;
    endfunction

    // a few illegal destinations only since they never leave the queue
    task automatic raise_request(input int i);
        req[i].send = units[i % NDEST];
        if (illegal_sent < 3 && $urandom_range(0, 15) == 0) begin
            req[i].dest = 4'b1111 - 4'($urandom_range(0, 2));
            illegal_sent++;
        end else begin
            req[i].dest = units[$urandom_range(0, NDEST - 1)];
        end
        reqv[i] = 1'b1;
    endtask

    always @(posedge clk) begin
        ack_seen       <= ack;
        grant_seen     <= grant;
        grant_req_seen <= grant_req;
        stall_seen     <= (reqv != '0) && (ack == '0);
    end

    initial begin
        int p;
        void'($urandom(32'he69f));
        forever begin
            @(negedge clk);
            if (rst_n) begin
                for (int i = 0; i < NREQ; i++) begin
                    if (reqv[i] && ack_seen[i]) begin
                        acked++;
                        reqv[i] = 1'b0;
                    end
                    if (!reqv[i] && new_reqs && $urandom_range(0, 3) == 0) begin
                        raise_request(i);
                    end
                end
                if (pull_rand) begin
                    pull = ($urandom_range(0, 3) != 0);
                end
                if (cfg_rand && $urandom_range(0, 15) == 0) begin
                    cfg_wr     = 1'b1;
                    cfg_enable = NDEST'($urandom | $urandom); // mostly enabled
                end else if (!cfg_rand && cfg_enable != '1) begin
                    cfg_wr     = 1'b1;
                    cfg_enable = '1;
                end else begin
                    cfg_wr = 1'b0;
                end
                done = '0;
                for (int d = 0; d < NDEST; d++) begin
                    if (done_timer[d] == 1) begin
                        done[d] = 1'b1;
                    end
                    if (done_timer[d] > 0) begin
                        done_timer[d]--;
                    end
                end
                if (grant_seen) begin
                    granted++;
                    p = unit_pos(grant_req_seen.dest);
                    if (p >= 0) begin
                        done_timer[p] = $urandom_range(1, 6);
                    end
                end
            end
        end
    end

    initial begin
        int waited;
        int quiet;
        rst_n      = 1'b0;
        req        = '0;
        reqv       = '0;
        pull       = 1'b0;
        done       = '0;
        cfg_wr     = 1'b0;
        cfg_enable = '1;
        for (int d = 0; d < NDEST; d++) begin
            done_timer[d] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        new_reqs  = 1'b1; // mixed traffic with random pull and config writes
        pull_rand = 1'b1;
        cfg_rand  = 1'b1;
        repeat (500) @(negedge clk);

        // back-pressure with pull held low
        pull_rand = 1'b0;
        cfg_rand  = 1'b0;
        pull      = 1'b0;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!stall_seen && waited < 100);
        if (!stall_seen) begin
            other_errors++;
            $display("timeout: the queue never refused a request while pull was low");
        end
        repeat (20) @(negedge clk);

        new_reqs = 1'b0; // drain everything still held or queued
        pull     = 1'b1;
        waited   = 0;
        quiet    = 0;
        while (!(reqv == '0 && quiet >= 20) && waited < 2000) begin
            @(negedge clk);
            quiet = grant_seen ? 0 : quiet + 1;
            waited++;
        end
        if (!(reqv == '0 && quiet >= 20)) begin
            other_errors++;
            $display("timeout: the queue did not drain after pull was raised");
        end
        if (acked != granted + illegal_sent || queued != illegal_sent) begin
            other_errors++;
            $display("requests lost or duplicated: %0d acked, %0d granted, %0d illegal, %0d left",
                     acked, granted, illegal_sent, queued);
        end

        $display("%0d assertion errors, %0d other errors (%0d acked, %0d granted)",
                 chk_errors, other_errors, acked, granted);
        if (chk_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== bus_arb_top.f ====
+incdir+include
verilog/bus_pkg.sv
verilog/prio_arbiter.sv
verilog/onehot_mux.sv
verilog/bus_req_queue.sv
verilog/dest_status.sv
verilog/bus_arb_top.sv
tb/tb_bus_arb_checks.sv
tb/tb_bus_arb_top.sv
